// ==== verif/mem_system_stimulus.txt ====
// op addr wdata exp_rdata exp_hit, hex fields, op R reads and W writes
// exp_rdata unused on writes; address bit 0 set means err is expected
W 0010 1111 0000 0
R 0010 0000 1111 1
R 0012 0000 0000 1
W 0014 2222 0000 1
R 0014 0000 2222 1
W 0810 AAAA 0000 0
R 0810 0000 AAAA 1
R 0010 0000 1111 0
R 0014 0000 2222 1
R 0816 0000 0000 0
R 0810 0000 AAAA 1
R 3000 0000 0000 0
W 3006 BEEF 0000 1
R 3007 0000 BEEF 1
W F8FE 5A5A 0000 0
R F8FE 0000 5A5A 1
W 00FE 1234 0000 0
R F8FE 0000 5A5A 0
R 00FE 0000 1234 0
R 0010 0000 1111 0
W 3001 7777 0000 1
R 3000 0000 7777 1
R 3006 0000 BEEF 1

// ==== all.f ====
+incdir+verilog
verilog/mem_sys_pkg.sv
verilog/cache_array.sv
verilog/banked_memory.sv
verilog/cache_controller.sv
verilog/mem_system.sv
verif/mem_system_tb.sv

// ==== Bender.yml ====
package:
  name: mem_system

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_sys_pkg.sv
      - verilog/cache_array.sv
      - verilog/banked_memory.sv
      - verilog/cache_controller.sv
      - verilog/mem_system.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/mem_system_tb.sv

// ==== verif/mem_system_tb.sv ====
// Run from the project root; accesses come from verif/mem_system_stimulus.txt
// One request in flight at a time, inputs change on the falling clock edge
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module mem_system_tb;

   // Cycle limits for the two handshake waits
   localparam int STALL_TIMEOUT = 50;
   localparam int DONE_TIMEOUT  = 200;

   logic clk;
   logic rst;
   logic [`MS_ADDR_W-1:0] addr;
   logic [`MS_WORD_W-1:0] data_in;
   logic rd;
   logic wr;
   logic [`MS_WORD_W-1:0] data_out;
   logic done;
   logic stall;
   logic cache_hit;
   logic err;

   // Access list from the data file
   logic op_wr_q [$];
   logic [`MS_ADDR_W-1:0] addr_q [$];
   logic [`MS_WORD_W-1:0] wdata_q [$];
   logic [`MS_WORD_W-1:0] rdata_q [$];
   logic hit_q [$];

   // Error tallies
   int data_errs;
   int hit_errs;
   int lat_errs;
   int err_errs;
   int proto_errs;
   int timeouts;
   int accesses;
   logic aborted;

   mem_system mem_system_inst (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   ////////////////////////////////////////
   // Stimulus file
   ////////////////////////////////////////

   // Lines start with R or W, comment lines with /
   task automatic load_stimulus();
      int fd;
      int c;
      int n;
      logic [31:0] f_addr;
      logic [31:0] f_wdata;
      logic [31:0] f_rdata;
      logic [31:0] f_hit;
      logic [8*128-1:0] rest;
      fd = $fopen("verif/mem_system_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file verif/mem_system_stimulus.txt");
         proto_errs++;
         aborted = 1'b1;
         return;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         if (c == "/") begin
            n = $fgets(rest, fd);
         end else if (c == "R" || c == "W") begin
            n = $fscanf(fd, "%h %h %h %h", f_addr, f_wdata, f_rdata, f_hit);
            if (n != 4) begin
               $display("Stimulus entry %0d is incomplete", addr_q.size());
               proto_errs++;
            end else begin
               op_wr_q.push_back(c == "W");
               addr_q.push_back(f_addr[`MS_ADDR_W-1:0]);
               wdata_q.push_back(f_wdata[`MS_WORD_W-1:0]);
               rdata_q.push_back(f_rdata[`MS_WORD_W-1:0]);
               hit_q.push_back(f_hit[0]);
            end
         end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
            $display("Stimulus file holds a line with an unknown operation");
            proto_errs++;
            n = $fgets(rest, fd);
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
      if (addr_q.size() == 0) begin
         $display("Stimulus file holds no accesses");
         proto_errs++;
      end
   endtask

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic check_reset_low(input string name, input logic value);
      if (value !== 1'b0) begin
         $display("FAILED %s: expected 0x0, got 0x%h after reset", name, value);
         proto_errs++;
      end
   endtask

   // Drive one access, wait for done and compare against the file
   task automatic run_access(input int idx);
      int cycles;
      logic is_wr;
      logic exp_err;
      logic [`MS_ADDR_W-1:0] a;
      is_wr = op_wr_q[idx];
      a = addr_q[idx];
      // Odd address is the only error the file can produce
      exp_err = a[0];

      cycles = 0;
      while (stall && cycles < STALL_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (stall) begin
         $display("Timed out waiting for stall to fall before access %0d", idx);
         timeouts++;
         aborted = 1'b1;
         return;
      end

      addr = a;
      data_in = wdata_q[idx];
      rd = ~is_wr;
      wr = is_wr;
      // err settles well before the accepting edge
      #2;
      if (err !== exp_err) begin
         $display("FAILED err: expected 0x%h, got 0x%h (access %0d)", exp_err, err, idx);
         err_errs++;
      end

      // Acceptance edge passed, request is captured
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
      addr = ~a;
      data_in = ~wdata_q[idx];
      cycles = 1;
      if (!stall) begin
         $display("Access %0d was not accepted, stall stayed low", idx);
         proto_errs++;
      end

      while (!done && cycles < DONE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Timed out waiting for done on access %0d", idx);
         timeouts++;
         aborted = 1'b1;
         return;
      end
      accesses++;

      // stall covers the done cycle too
      if (!stall) begin
         $display("stall dropped before the done cycle of access %0d", idx);
         proto_errs++;
      end
      if (cache_hit !== hit_q[idx]) begin
         $display("FAILED cache_hit: expected 0x%h, got 0x%h (access %0d)",
                  hit_q[idx], cache_hit, idx);
         hit_errs++;
      end
      if (hit_q[idx] && cycles != 2) begin
         $display("FAILED done latency: expected 0x2, got 0x%h cycles (access %0d)",
                  cycles, idx);
         lat_errs++;
      end
      if (!is_wr && data_out !== rdata_q[idx]) begin
         $display("FAILED data_out: expected 0x%h, got 0x%h (access %0d)",
                  rdata_q[idx], data_out, idx);
         data_errs++;
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      int total;
      clk = 1'b0;
      rst = 1'b1;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      data_errs = 0;
      hit_errs = 0;
      lat_errs = 0;
      err_errs = 0;
      proto_errs = 0;
      timeouts = 0;
      accesses = 0;
      aborted = 1'b0;

      load_stimulus();

      // Reset for 5 cycles, released on a falling edge
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_reset_low("done", done);
      check_reset_low("stall", stall);
      check_reset_low("cache_hit", cache_hit);
      check_reset_low("err", err);

      for (int i = 0; i < addr_q.size() && !aborted; i++) begin
         run_access(i);
      end

      total = data_errs + hit_errs + lat_errs + err_errs + proto_errs + timeouts;
      $display("Accesses: %0d, data: %0d, hit: %0d, latency: %0d, err flag: %0d, ",
               accesses, data_errs, hit_errs, lat_errs, err_errs,
               "protocol: %0d, timeouts: %0d, total errors: %0d",
               proto_errs, timeouts, total);
      if (total == 0 && !aborted) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog/mem_system.sv ====
// Cache plus banked memory behind a request / stall / done handshake
// err merges requester and memory faults; it is combinational
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module mem_system (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`MS_ADDR_W-1:0]  addr,
   input  mem_sys_pkg::word_t     data_in,
   input  logic                   rd,
   input  logic                   wr,
   output mem_sys_pkg::word_t     data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err
);
   import mem_sys_pkg::*;

   // Controller to array
   logic c_en;
   logic c_comp;
   logic c_write;
   tag_t c_tag;
   index_t c_index;
   woff_t c_woff;
   word_t c_wdata;
   logic c_valid_in;
   word_t c_rdata;
   logic c_hit;
   logic c_dirty;
   logic c_valid;
   tag_t c_tag_out;

   // Controller to memory
   logic [`MS_ADDR_W-1:0] m_addr;
   word_t m_wdata;
   logic m_rd;
   logic m_wr;
   word_t m_rdata;
   logic m_stall;
   logic m_err;

   logic ctrl_err;

   assign err = ctrl_err | m_err;

   cache_controller cache_controller_inst (
      .clk        (clk),
      .rst        (rst),
      .addr       (addr),
      .data_in    (data_in),
      .rd         (rd),
      .wr         (wr),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (ctrl_err),
      .c_en       (c_en),
      .c_comp     (c_comp),
      .c_write    (c_write),
      .c_tag      (c_tag),
      .c_index    (c_index),
      .c_woff     (c_woff),
      .c_wdata    (c_wdata),
      .c_valid_in (c_valid_in),
      .c_rdata    (c_rdata),
      .c_hit      (c_hit),
      .c_dirty    (c_dirty),
      .c_valid    (c_valid),
      .c_tag_out  (c_tag_out),
      .m_addr     (m_addr),
      .m_wdata    (m_wdata),
      .m_rd       (m_rd),
      .m_wr       (m_wr),
      .m_rdata    (m_rdata),
      .m_stall    (m_stall)
   );

   cache_array cache_array_inst (
      .clk        (clk),
      .rst        (rst),
      .c_en       (c_en),
      .c_comp     (c_comp),
      .c_write    (c_write),
      .c_tag      (c_tag),
      .c_index    (c_index),
      .c_woff     (c_woff),
      .c_wdata    (c_wdata),
      .c_valid_in (c_valid_in),
      .c_rdata    (c_rdata),
      .c_hit      (c_hit),
      .c_dirty    (c_dirty),
      .c_valid    (c_valid),
      .c_tag_out  (c_tag_out)
   );

   banked_memory banked_memory_inst (
      .clk     (clk),
      .rst     (rst),
      .m_addr  (m_addr),
      .m_wdata (m_wdata),
      .m_rd    (m_rd),
      .m_wr    (m_wr),
      .m_rdata (m_rdata),
      .m_stall (m_stall),
      .m_err   (m_err)
   );

endmodule

// ==== verilog/cache_controller.sv ====
// One request at a time; addr and data_in are captured at acceptance
// Unaligned requests flag err and proceed with address bit 0 ignored
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module cache_controller (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`MS_ADDR_W-1:0]  addr,
   input  mem_sys_pkg::word_t     data_in,
   input  logic                   rd,
   input  logic                   wr,
   output mem_sys_pkg::word_t     data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err,
   output logic                   c_en,
   output logic                   c_comp,
   output logic                   c_write,
   output mem_sys_pkg::tag_t      c_tag,
   output mem_sys_pkg::index_t    c_index,
   output mem_sys_pkg::woff_t     c_woff,
   output mem_sys_pkg::word_t     c_wdata,
   output logic                   c_valid_in,
   input  mem_sys_pkg::word_t     c_rdata,
   input  logic                   c_hit,
   input  logic                   c_dirty,
   input  logic                   c_valid,
   input  mem_sys_pkg::tag_t      c_tag_out,
   output logic [`MS_ADDR_W-1:0]  m_addr,
   output mem_sys_pkg::word_t     m_wdata,
   output logic                   m_rd,
   output logic                   m_wr,
   input  mem_sys_pkg::word_t     m_rdata,
   input  logic                   m_stall
);
   import mem_sys_pkg::*;

   localparam int LAT = `MS_MEM_LATENCY;

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   // Captured request
   tag_t req_tag;
   index_t req_index;
   woff_t req_woff;
   word_t req_data;
   logic req_wr;

   // Words moved so far in evict / fill issue
   logic [2:0] xfer_cnt;
   logic cnt_clr;
   logic cnt_inc;

   // Outstanding fill reads, one slot per cycle of latency
   logic [LAT-1:0] rd_vld_q;
   woff_t rd_off_q [LAT];
   logic issue;
   logic ret_vld;
   woff_t ret_off;

   logic accept;

   assign accept  = (state == st_idle) & (rd ^ wr);
   assign issue   = m_rd & ~m_stall;
   assign ret_vld = rd_vld_q[LAT-1];
   assign ret_off = rd_off_q[LAT-1];

   // Both strobes, or an odd address, while we are taking requests
   assign err = ~stall & ((rd & wr) | ((rd | wr) & addr[0]));

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= st_idle;
         stall    <= 1'b0;
         req_wr   <= 1'b0;
         xfer_cnt <= '0;
         rd_vld_q <= '0;
      end else begin
         state <= state_nxt;
         // High from the cycle after acceptance through done
         if (accept) begin
            stall <= 1'b1;
         end else if (done) begin
            stall <= 1'b0;
         end
         if (accept) begin
            req_wr <= wr;
         end
         if (cnt_clr) begin
            xfer_cnt <= '0;
         end else if (cnt_inc) begin
            xfer_cnt <= xfer_cnt + 3'd1;
         end
         rd_vld_q <= {rd_vld_q[LAT-2:0], issue};
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_tag   <= addr[`MS_ADDR_W-1 -: `MS_TAG_W];
         req_index <= addr[`MS_INDEX_W+2:3];
         req_woff  <= addr[2:1];
         req_data  <= data_in;
      end
      // Offset rides along with each fill read
      rd_off_q[0] <= xfer_cnt[1:0];
      for (int s = 1; s < LAT; s++) begin
         rd_off_q[s] <= rd_off_q[s-1];
      end
   end

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////

   always_comb begin
      state_nxt  = state;
      cnt_clr    = 1'b0;
      cnt_inc    = 1'b0;
      done       = 1'b0;
      cache_hit  = 1'b0;
      data_out   = '0;
      c_en       = 1'b0;
      c_comp     = 1'b0;
      c_write    = 1'b0;
      c_tag      = req_tag;
      c_index    = req_index;
      c_woff     = req_woff;
      c_wdata    = req_data;
      c_valid_in = 1'b0;
      m_addr     = {req_tag, req_index, xfer_cnt[1:0], 1'b0};
      m_wdata    = c_rdata;
      m_rd       = 1'b0;
      m_wr       = 1'b0;

      case (state)
         st_idle: begin
            if (accept) begin
               state_nxt = st_lookup;
            end
         end

         // Tag compare; a write hit updates the word right here
         st_lookup: begin
            c_en    = 1'b1;
            c_comp  = 1'b1;
            cnt_clr = 1'b1;
            if (c_hit) begin
               c_write   = req_wr;
               state_nxt = st_hit_return;
            end else if (c_valid & c_dirty) begin
               state_nxt = st_evict;
            end else begin
               state_nxt = st_fill;
            end
         end

         st_hit_return: begin
            c_en      = 1'b1;
            done      = 1'b1;
            cache_hit = 1'b1;
            data_out  = c_rdata;
            state_nxt = st_idle;
         end

         // Victim words go back under the old tag
         st_evict: begin
            c_en    = 1'b1;
            c_woff  = xfer_cnt[1:0];
            m_addr  = {c_tag_out, req_index, xfer_cnt[1:0], 1'b0};
            m_wdata = c_rdata;
            m_wr    = 1'b1;
            if (!m_stall) begin
               if (xfer_cnt[1:0] == 2'd3) begin
                  cnt_clr   = 1'b1;
                  state_nxt = st_fill;
               end else begin
                  cnt_inc = 1'b1;
               end
            end
         end

         // Issue 4 reads, write each word back as it returns
         st_fill: begin
            m_rd    = ~xfer_cnt[2];
            cnt_inc = m_rd & ~m_stall;
            if (ret_vld) begin
               c_en       = 1'b1;
               c_write    = 1'b1;
               c_woff     = ret_off;
               c_wdata    = m_rdata;
               c_valid_in = 1'b1;
               // Last word of the line landed
               if (ret_off == 2'd3) begin
                  state_nxt = st_miss_finish;
               end
            end
         end

         st_miss_finish: begin
            c_en      = 1'b1;
            c_comp    = 1'b1;
            c_write   = req_wr;
            state_nxt = st_miss_return;
         end

         st_miss_return: begin
            c_en      = 1'b1;
            done      = 1'b1;
            data_out  = c_rdata;
            state_nxt = st_idle;
         end

         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   a_state_legal: assert property (@(posedge clk) disable iff (rst)
      state inside {st_idle, st_lookup, st_hit_return, st_evict,
                    st_fill, st_miss_finish, st_miss_return});

   a_done_pulse: assert property (@(posedge clk) disable iff (rst)
      done |=> !done);

   a_idle_no_stall: assert property (@(posedge clk) disable iff (rst)
      (state == st_idle) |-> !stall);

endmodule

// ==== verilog/banked_memory.sv ====
// Four word-interleaved banks with fixed read latency
// A busy bank raises m_stall; stalled or erroneous requests are not performed and must be held
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module banked_memory (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`MS_ADDR_W-1:0]  m_addr,
   input  mem_sys_pkg::word_t     m_wdata,
   input  logic                   m_rd,
   input  logic                   m_wr,
   output mem_sys_pkg::word_t     m_rdata,
   output logic                   m_stall,
   output logic                   m_err
);
   import mem_sys_pkg::*;

   localparam int BANKS  = `MS_WORDS_PER_LINE;
   localparam int ROW_W  = `MS_ADDR_W - 3;
   localparam int ROWS   = 1 << ROW_W;
   localparam int BUSY_W = $clog2(`MS_BANK_BUSY);
   localparam int LAT    = `MS_MEM_LATENCY;

   // Bank arrays holding 32K words in total
   word_t mem_q [BANKS][ROWS];
   // Cycles left before each bank frees up
   logic [BUSY_W-1:0] busy_q [BANKS];
   // Read data pipeline
   word_t rd_pipe_q [LAT];

   logic [1:0] bank;
   logic [ROW_W-1:0] row;
   logic access;
   logic go;

   // Power-up contents are zero
   initial begin
      for (int b = 0; b < BANKS; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            mem_q[b][r] = '0;
         end
      end
   end

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   // Bank from the word offset bits and row from the rest
   assign bank   = m_addr[2:1];
   assign row    = m_addr[`MS_ADDR_W-1:3];
   assign access = m_rd | m_wr;

   assign m_err   = (m_rd & m_wr) | (access & m_addr[0]);
   assign m_stall = access & (busy_q[bank] != '0);
   assign go      = access & ~m_stall & ~m_err;

   // Busy timers
   always_ff @(posedge clk) begin
      for (int b = 0; b < BANKS; b++) begin
         if (rst) begin
            busy_q[b] <= '0;
         end else if (go && (bank == b[1:0])) begin
            busy_q[b] <= BUSY_W'(`MS_BANK_BUSY - 1);
         end else if (busy_q[b] != '0) begin
            busy_q[b] <= busy_q[b] - 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Data path
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (go & m_wr) begin
         mem_q[bank][row] <= m_wdata;
      end
      // Stage 0 samples the array and later stages shift
      rd_pipe_q[0] <= mem_q[bank][row];
      for (int s = 1; s < LAT; s++) begin
         rd_pipe_q[s] <= rd_pipe_q[s-1];
      end
   end

   assign m_rdata = rd_pipe_q[LAT-1];

   // Controller drives one direction at a time
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
      !(m_rd && m_wr));

endmodule

// ==== verilog/cache_array.sv ====
// Direct-mapped storage, reads combinational, writes on the clock edge
// Compare writes land only on a hit; fill writes always land
`timescale 1ns/1ps
`include "mem_sys_params.svh"

module cache_array (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 c_en,
   input  logic                 c_comp,
   input  logic                 c_write,
   input  mem_sys_pkg::tag_t    c_tag,
   input  mem_sys_pkg::index_t  c_index,
   input  mem_sys_pkg::woff_t   c_woff,
   input  mem_sys_pkg::word_t   c_wdata,
   input  logic                 c_valid_in,
   output mem_sys_pkg::word_t   c_rdata,
   output logic                 c_hit,
   output logic                 c_dirty,
   output logic                 c_valid,
   output mem_sys_pkg::tag_t    c_tag_out
);
   import mem_sys_pkg::*;

   localparam int LINES = 1 << `MS_INDEX_W;
   localparam int WORDS = LINES * `MS_WORDS_PER_LINE;

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   // Line data, addressed by {index, offset}
   word_t data_q [WORDS];
   tag_t tag_q [LINES];
   // Per-line state bits
   logic [LINES-1:0] valid_q;
   logic [LINES-1:0] dirty_q;

   logic wr_fill;
   logic wr_comp;

   ////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////

   assign c_rdata   = data_q[{c_index, c_woff}];
   assign c_tag_out = tag_q[c_index];
   assign c_valid   = valid_q[c_index];
   assign c_dirty   = dirty_q[c_index];
   // Tag match only counts on a valid line
   assign c_hit     = c_valid & (c_tag_out == c_tag);

   // Fill from memory vs. requester write
   assign wr_fill = c_en & c_write & ~c_comp;
   assign wr_comp = c_en & c_write & c_comp & c_hit;

   // Valid / dirty bookkeeping
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_fill) begin
         valid_q[c_index] <= c_valid_in;
         // Freshly filled line matches memory
         dirty_q[c_index] <= 1'b0;
      end else if (wr_comp) begin
         dirty_q[c_index] <= 1'b1;
      end
   end

   // Tag and data writes
   always_ff @(posedge clk) begin
      if (wr_fill) begin
         tag_q[c_index] <= c_tag;
      end
      if (wr_fill | wr_comp) begin
         data_q[{c_index, c_woff}] <= c_wdata;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Controller never writes with the array disabled
   a_write_needs_en: assert property (@(posedge clk) disable iff (rst)
      c_write |-> c_en);

   // Compare writes are only issued once the line is resident
   a_comp_write_hits: assert property (@(posedge clk) disable iff (rst)
      (c_en & c_write & c_comp) |-> c_hit);

endmodule

// ==== verilog/mem_sys_pkg.sv ====
// Shared types for the memory system
// Field widths follow mem_sys_params.svh
`include "mem_sys_params.svh"

package mem_sys_pkg;

   // Controller FSM states
   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_hit_return,
      st_evict,
      st_fill,
      st_miss_finish,
      st_miss_return
   } ctrl_state_t;

   // Address fields
   typedef logic [`MS_TAG_W-1:0] tag_t;
   typedef logic [`MS_INDEX_W-1:0] index_t;
   // Word within a line
   typedef logic [$clog2(`MS_WORDS_PER_LINE)-1:0] woff_t;

   // Data word
   typedef logic [`MS_WORD_W-1:0] word_t;

endpackage

// ==== verilog/mem_sys_params.svh ====
// Geometry and timing constants for the cache and banked memory
// Word addresses only; address bit 0 must be zero on every access
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

////////////////////////////////////////
// Address and data geometry
////////////////////////////////////////

// Byte address and data word
`define MS_ADDR_W 16
`define MS_WORD_W 16

// Tag / index / offset split of the address
`define MS_TAG_W 5
`define MS_INDEX_W 8
// Words per line, offset in address bits 2:1
`define MS_WORDS_PER_LINE 4

////////////////////////////////////////
// Memory timing
////////////////////////////////////////

// Read data appears this many cycles after the request
`define MS_MEM_LATENCY 2
// Bank occupancy per access, access cycle included
`define MS_BANK_BUSY 4

`endif
